// ==== project.f ====
+incdir+logic
logic/mmio_pkg.sv
logic/board_cr_pkg.sv
logic/mmio_if.sv
logic/mmio_req_decode.sv
logic/mmio_cr_execute.sv
logic/mmio_rsp_result.sv
logic/mmio_top.sv
verif/mmio_assertions.sv
verif/mmio_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MMIO control-register testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module mmio_tb \
    -f project.f

./obj_dir/Vmmio_tb 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation finished clean, see sim.log"

// ==== verif/mmio_tb.sv ====
`timescale 1ns/10ps
`include "mmio_params.svh"

module mmio_tb;
    import mmio_pkg::*;
    import board_cr_pkg::*;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 100;

    logic    clk_50;
    logic    rst_n;
    logic    req_valid;
    opcode_t req_opcode;
    addr_t   req_address;
    data_t   req_data;
    logic    credit_return;
    logic    rsp_valid;
    opcode_t rsp_opcode;
    addr_t   rsp_address;
    data_t   rsp_data;
    logic    button_0;
    logic    button_1;
    switch_t switch;
    seg7_t   seg7 [6];
    led_t    led;

    // Expected responses in request order
    opcode_t exp_op_q [$];
    addr_t   exp_addr_q [$];
    data_t   exp_data_q [$];
    logic    exp_rd_q [$];

    // Reference copy of the read-write registers
    // LED sits at index 6
    logic [6:0] model [7];

    int    credits = `MMIO_CREDITS;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    rsp_seen = 0;
    string test_name = "startup";

    mmio_top dut_i (
        .clk_50        (clk_50),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_opcode    (req_opcode),
        .req_address   (req_address),
        .req_data      (req_data),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_opcode    (rsp_opcode),
        .rsp_address   (rsp_address),
        .rsp_data      (rsp_data),
        .button_0      (button_0),
        .button_1      (button_1),
        .switch        (switch),
        .seg7_0        (seg7[0]),
        .seg7_1        (seg7[1]),
        .seg7_2        (seg7[2]),
        .seg7_3        (seg7[3]),
        .seg7_4        (seg7[4]),
        .seg7_5        (seg7[5]),
        .led           (led)
    );

    // 50 MHz board clock
    initial begin
        clk_50 = 1'b0;
        forever #10 clk_50 = ~clk_50;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: %s expected 0x%08h actual 0x%08h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(string reason);
        $display("Timeout in %s: %s", test_name, reason);
        $display("Test failures found");
        $finish;
    endtask

    // Register map indexed like cr_index_t
    function automatic offset_t offset_of(int idx);
        case (idx)
            0:       return `CR_SEG7_0;
            1:       return `CR_SEG7_1;
            2:       return `CR_SEG7_2;
            3:       return `CR_SEG7_3;
            4:       return `CR_SEG7_4;
            5:       return `CR_SEG7_5;
            6:       return `CR_LED;
            7:       return `CR_BUTTON_0;
            8:       return `CR_BUTTON_1;
            default: return `CR_SWITCH;
        endcase
    endfunction

    function automatic logic [6:0] output_of(int idx);
        return (idx < 6) ? seg7[idx] : led;
    endfunction

    // Called on a falling edge
    // Holds req_valid for one cycle
    task automatic send_request(opcode_t op, addr_t addr, data_t data, data_t exp_data);
        int waited;
        waited = 0;
        while (credits == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_50);
            waited++;
        end
        if (credits == 0) begin
            abort_run("no credit came back to the requester");
        end else begin
            req_valid   = 1'b1;
            req_opcode  = op;
            req_address = addr;
            req_data    = data;
            credits--;
            if (op == WR)
                exp_op_q.push_back(WR_RSP);
            else
                exp_op_q.push_back(RD_RSP);
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(exp_data);
            exp_rd_q.push_back(op == RD);
            @(negedge clk_50);
            req_valid = 1'b0;
        end
    endtask

    // Until every outstanding request has its response
    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_op_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk_50);
            waited++;
        end
        if (exp_op_q.size() != 0)
            abort_run("a response never arrived");
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", test_name, errors - test_errors);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // Response monitor sampled mid-cycle
    always @(negedge clk_50) begin
        if (credit_return)
            credits++;
        if (rsp_valid) begin
            rsp_seen++;
            if (exp_op_q.size() == 0) begin
                $display("Unexpected response in %s with nothing outstanding", test_name);
                errors++;
            end else begin
                check_value("rsp_opcode", 32'(exp_op_q.pop_front()), 32'(rsp_opcode));
                check_value("rsp_address", exp_addr_q.pop_front(), rsp_address);
                // Write response data is not defined
                if (exp_rd_q.pop_front())
                    check_value("rsp_data", exp_data_q.pop_front(), rsp_data);
                else
                    void'(exp_data_q.pop_front());
            end
        end
    end

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic reset_values();
        begin_test("reset_values");
        check_value("rsp_valid", 0, 32'(rsp_valid));
        check_value("credit_return", 0, 32'(credit_return));
        check_value("rsp_opcode", 0, 32'(rsp_opcode));
        check_value("rsp_address", 0, rsp_address);
        check_value("rsp_data", 0, rsp_data);
        for (int i = 0; i < 7; i++)
            check_value("board output", 0, 32'(output_of(i)));
        end_test();
    endtask

    task automatic register_access();
        data_t value;
        addr_t addr;
        begin_test("register_access");
        for (int i = 0; i < 7; i++) begin
            value    = $urandom;
            addr     = {12'h000, offset_of(i)};
            model[i] = value[6:0];
            send_request(WR, addr, value, '0);
            wait_idle();
            check_value("board output", 32'(model[i]), 32'(output_of(i)));
            send_request(RD, addr, '0, 32'(model[i]));
            wait_idle();
        end
        end_test();
    endtask

    task automatic board_inputs();
        logic [31:0] rnd;
        begin_test("board_inputs");
        for (int n = 0; n < 3; n++) begin
            rnd      = $urandom;
            button_0 = rnd[0];
            button_1 = rnd[1];
            switch   = rnd[11:2];
            send_request(RD, {12'h000, offset_of(7)}, '0, 32'(rnd[0]));
            send_request(RD, {12'h000, offset_of(8)}, '0, 32'(rnd[1]));
            send_request(RD, {12'h000, offset_of(9)}, '0, 32'(rnd[11:2]));
            wait_idle();
        end
        end_test();
    endtask

    task automatic unmapped_access();
        offset_t holes [4];
        begin_test("unmapped_access");
        holes = '{20'h0_001C, 20'h0_002C, 20'h0_0100, 20'hF_FFFC};
        for (int i = 0; i < 4; i++) begin
            send_request(RD, {12'h000, holes[i]}, '0, '0);
            send_request(WR, {12'h000, holes[i]}, $urandom, '0);
        end
        // Buttons and switches ignore writes
        for (int i = 7; i < 10; i++)
            send_request(WR, {12'h000, offset_of(i)}, $urandom, '0);
        wait_idle();
        for (int i = 0; i < 7; i++)
            check_value("board output", 32'(model[i]), 32'(output_of(i)));
        end_test();
    endtask

    task automatic upper_address();
        logic [31:0] rnd;
        data_t       value;
        begin_test("upper_address");
        for (int i = 0; i < 7; i++) begin
            rnd      = $urandom;
            value    = $urandom;
            model[i] = value[6:0];
            send_request(WR, {1'b1, rnd[30:20], offset_of(i)}, value, '0);
            rnd = $urandom;
            send_request(RD, {1'b1, rnd[30:20], offset_of(i)}, '0, 32'(model[i]));
        end
        rnd = $urandom;
        send_request(RD, {1'b1, rnd[30:20], offset_of(9)}, '0, 32'(switch));
        wait_idle();
        for (int i = 0; i < 7; i++)
            check_value("board output", 32'(model[i]), 32'(output_of(i)));
        end_test();
    endtask

    task automatic back_to_back();
        data_t first;
        data_t second;
        int    start_seen;
        begin_test("back_to_back");
        check_value("credits before", `MMIO_CREDITS, credits);
        first      = $urandom;
        second     = $urandom;
        model[2]   = first[6:0];
        model[6]   = second[6:0];
        start_seen = rsp_seen;
        // Four requests on consecutive cycles
        send_request(WR, {12'h000, offset_of(2)}, first, '0);
        send_request(RD, {12'h000, offset_of(2)}, '0, 32'(model[2]));
        send_request(WR, {12'h000, offset_of(6)}, second, '0);
        send_request(RD, {12'h000, offset_of(9)}, '0, 32'(switch));
        wait_idle();
        // Any spurious response shows up within the pipeline depth
        repeat (3) @(negedge clk_50);
        check_value("credits after", `MMIO_CREDITS, credits);
        check_value("response count", 4, rsp_seen - start_seen);
        check_value("seg7_2", 32'(model[2]), 32'(output_of(2)));
        check_value("led", 32'(model[6]), 32'(output_of(6)));
        end_test();
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'h3eb6));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_opcode  = RD;
        req_address = '0;
        req_data    = '0;
        button_0    = 1'b0;
        button_1    = 1'b0;
        switch      = '0;
        for (int i = 0; i < 7; i++)
            model[i] = '0;
        repeat (8) @(negedge clk_50);
        rst_n = 1'b1;
        @(negedge clk_50);
        reset_values();
        register_access();
        board_inputs();
        unmapped_access();
        upper_address();
        back_to_back();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== verif/mmio_assertions.sv ====
`timescale 1ns/10ps

module mmio_assertions (
    input logic              clk_50,
    input logic              rst_n,
    input logic              req_valid,
    input mmio_pkg::opcode_t req_opcode,
    input logic              rsp_valid,
    input logic              credit_return
);
    import mmio_pkg::*;

    // ------------------------------------------------------------
    // Response and credit protocol
    // ------------------------------------------------------------

    // One credit back with every response
    credit_with_response: assert property (
        @(posedge clk_50) rsp_valid == credit_return
    ) else $error("credit_return and rsp_valid differ");

    // Fixed three-cycle pipeline latency
    response_latency: assert property (
        @(posedge clk_50) disable iff (!rst_n)
        (req_valid && ((req_opcode == RD) || (req_opcode == WR))) |-> ##3 rsp_valid
    ) else $error("no rsp_valid three cycles after a request");

    // Quiet response port in reset
    idle_in_reset: assert property (
        @(posedge clk_50) !rst_n |-> !rsp_valid
    ) else $error("rsp_valid high during reset");

endmodule

bind mmio_top mmio_assertions assertions_i (
    .clk_50        (clk_50),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_opcode    (req_opcode),
    .rsp_valid     (rsp_valid),
    .credit_return (credit_return)
);

// ==== logic/mmio_top.sv ====
`timescale 1ns/10ps

module mmio_top (
    input  logic                  clk_50,
    input  logic                  rst_n,
    // Fabric request
    input  logic                  req_valid,
    input  mmio_pkg::opcode_t     req_opcode,
    input  mmio_pkg::addr_t       req_address,
    input  mmio_pkg::data_t       req_data,
    // Credit back to the requester
    output logic                  credit_return,
    // Fabric response
    output logic                  rsp_valid,
    output mmio_pkg::opcode_t     rsp_opcode,
    output mmio_pkg::addr_t       rsp_address,
    output mmio_pkg::data_t       rsp_data,
    // Board inputs
    input  logic                  button_0,
    input  logic                  button_1,
    input  board_cr_pkg::switch_t switch,
    // Board outputs
    output board_cr_pkg::seg7_t   seg7_0,
    output board_cr_pkg::seg7_t   seg7_1,
    output board_cr_pkg::seg7_t   seg7_2,
    output board_cr_pkg::seg7_t   seg7_3,
    output board_cr_pkg::seg7_t   seg7_4,
    output board_cr_pkg::seg7_t   seg7_5,
    output board_cr_pkg::led_t    led
);

    // Stage links
    cr_req_if req_bus ();
    cr_rsp_if rsp_bus ();

    // ------------------------------------------------------------
    // Decode, execute, result
    // ------------------------------------------------------------
    mmio_req_decode decode_i (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_opcode  (req_opcode),
        .req_address (req_address),
        .req_data    (req_data),
        .req         (req_bus.decode)
    );

    mmio_cr_execute execute_i (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .req      (req_bus.execute),
        .rsp      (rsp_bus.execute),
        .button_0 (button_0),
        .button_1 (button_1),
        .switch   (switch),
        .seg7_0   (seg7_0),
        .seg7_1   (seg7_1),
        .seg7_2   (seg7_2),
        .seg7_3   (seg7_3),
        .seg7_4   (seg7_4),
        .seg7_5   (seg7_5),
        .led      (led)
    );

    mmio_rsp_result result_i (
        .clk_50        (clk_50),
        .rst_n         (rst_n),
        .rsp           (rsp_bus.result),
        .rsp_valid     (rsp_valid),
        .rsp_opcode    (rsp_opcode),
        .rsp_address   (rsp_address),
        .rsp_data      (rsp_data),
        .credit_return (credit_return)
    );

endmodule

// ==== logic/mmio_rsp_result.sv ====
`timescale 1ns/10ps

module mmio_rsp_result (
    input  logic              clk_50,
    input  logic              rst_n,
    cr_rsp_if.result          rsp,
    output logic              rsp_valid,
    output mmio_pkg::opcode_t rsp_opcode,
    output mmio_pkg::addr_t   rsp_address,
    output mmio_pkg::data_t   rsp_data,
    output logic              credit_return
);
    import mmio_pkg::*;

    // First response stage
    logic  s1_valid;
    logic  s1_is_write;
    addr_t s1_address;
    data_t s1_data;

    // ------------------------------------------------------------
    // Stage one
    // ------------------------------------------------------------
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rsp.valid;
        end
    end

    always_ff @(posedge clk_50) begin
        if (rsp.valid) begin
            s1_is_write <= rsp.is_write;
            s1_address  <= rsp.address;
            s1_data     <= rsp.rd_data;
        end
    end

    // ------------------------------------------------------------
    // Stage two, the response port
    // ------------------------------------------------------------
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
            rsp_opcode    <= RD;
            rsp_address   <= '0;
            rsp_data      <= '0;
        end else begin
            rsp_valid     <= s1_valid;
            // One credit back per response
            credit_return <= s1_valid;
            if (s1_valid) begin
                rsp_opcode  <= s1_is_write ? WR_RSP : RD_RSP;
                rsp_address <= s1_address;
                rsp_data    <= s1_data;
            end
        end
    end

endmodule

// ==== logic/mmio_cr_execute.sv ====
`timescale 1ns/10ps

module mmio_cr_execute (
    input  logic                  clk_50,
    input  logic                  rst_n,
    cr_req_if.execute             req,
    cr_rsp_if.execute             rsp,
    input  logic                  button_0,
    input  logic                  button_1,
    input  board_cr_pkg::switch_t switch,
    output board_cr_pkg::seg7_t   seg7_0,
    output board_cr_pkg::seg7_t   seg7_1,
    output board_cr_pkg::seg7_t   seg7_2,
    output board_cr_pkg::seg7_t   seg7_3,
    output board_cr_pkg::seg7_t   seg7_4,
    output board_cr_pkg::seg7_t   seg7_5,
    output board_cr_pkg::led_t    led
);
    import mmio_pkg::*;
    import board_cr_pkg::*;

    localparam int NUM_SEG7 = 6;

    // Read-write registers, also the board outputs
    seg7_t seg7_q    [NUM_SEG7];
    seg7_t seg7_next [NUM_SEG7];
    led_t  led_q;
    led_t  led_next;
    logic  wr_en;
    logic  rd_en;

    assign wr_en = req.valid && req.is_write;
    assign rd_en = req.valid && !req.is_write;

    // ------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------
    always_comb begin
        seg7_next = seg7_q;
        led_next  = led_q;
        if (wr_en) begin
            // Low seven data bits only
            case (req.index)
                IDX_SEG7_0: seg7_next[0] = req.wr_data[6:0];
                IDX_SEG7_1: seg7_next[1] = req.wr_data[6:0];
                IDX_SEG7_2: seg7_next[2] = req.wr_data[6:0];
                IDX_SEG7_3: seg7_next[3] = req.wr_data[6:0];
                IDX_SEG7_4: seg7_next[4] = req.wr_data[6:0];
                IDX_SEG7_5: seg7_next[5] = req.wr_data[6:0];
                IDX_LED:    led_next     = req.wr_data[6:0];
                // Read-only or unmapped, write is dropped
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            seg7_q <= '{default: '0};
            led_q  <= '0;
        end else begin
            seg7_q <= seg7_next;
            led_q  <= led_next;
        end
    end

    // Board outputs straight from the registers
    assign seg7_0 = seg7_q[0];
    assign seg7_1 = seg7_q[1];
    assign seg7_2 = seg7_q[2];
    assign seg7_3 = seg7_q[3];
    assign seg7_4 = seg7_q[4];
    assign seg7_5 = seg7_q[5];
    assign led    = led_q;

    // ------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------
    always_comb begin
        rsp.rd_data = '0;
        if (rd_en) begin
            // Next-state view so a same-cycle write is visible
            case (req.index)
                IDX_SEG7_0:   rsp.rd_data = data_t'(seg7_next[0]);
                IDX_SEG7_1:   rsp.rd_data = data_t'(seg7_next[1]);
                IDX_SEG7_2:   rsp.rd_data = data_t'(seg7_next[2]);
                IDX_SEG7_3:   rsp.rd_data = data_t'(seg7_next[3]);
                IDX_SEG7_4:   rsp.rd_data = data_t'(seg7_next[4]);
                IDX_SEG7_5:   rsp.rd_data = data_t'(seg7_next[5]);
                IDX_LED:      rsp.rd_data = data_t'(led_next);
                // Live board inputs
                IDX_BUTTON_0: rsp.rd_data = data_t'(button_0);
                IDX_BUTTON_1: rsp.rd_data = data_t'(button_1);
                IDX_SWITCH:   rsp.rd_data = data_t'(switch);
                default:      rsp.rd_data = '0;
            endcase
        end
    end

    // Control and address pass through
    assign rsp.valid    = req.valid;
    assign rsp.is_write = req.is_write;
    assign rsp.address  = req.address;

endmodule

// ==== logic/mmio_req_decode.sv ====
`timescale 1ns/10ps
`include "mmio_params.svh"

module mmio_req_decode (
    input  logic              clk_50,
    input  logic              rst_n,
    input  logic              req_valid,
    input  mmio_pkg::opcode_t req_opcode,
    input  mmio_pkg::addr_t   req_address,
    input  mmio_pkg::data_t   req_data,
    cr_req_if.decode          req
);
    import mmio_pkg::*;
    import board_cr_pkg::*;

    offset_t   offset;
    cr_index_t index_next;
    logic      access;

    // Response opcodes arriving here are dropped
    assign access = req_valid && ((req_opcode == RD) || (req_opcode == WR));

    // Upper address bits are ignored
    assign offset = req_address[`MMIO_OFFSET_W-1:0];

    // ------------------------------------------------------------
    // Offset to register index
    // ------------------------------------------------------------
    always_comb begin
        case (offset)
            `CR_SEG7_0:   index_next = IDX_SEG7_0;
            `CR_SEG7_1:   index_next = IDX_SEG7_1;
            `CR_SEG7_2:   index_next = IDX_SEG7_2;
            `CR_SEG7_3:   index_next = IDX_SEG7_3;
            `CR_SEG7_4:   index_next = IDX_SEG7_4;
            `CR_SEG7_5:   index_next = IDX_SEG7_5;
            `CR_LED:      index_next = IDX_LED;
            `CR_BUTTON_0: index_next = IDX_BUTTON_0;
            `CR_BUTTON_1: index_next = IDX_BUTTON_1;
            `CR_SWITCH:   index_next = IDX_SWITCH;
            // Unmapped offset
            default:      index_next = IDX_NONE;
        endcase
    end

    // Stage valid
    always_ff @(posedge clk_50 or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= access;
        end
    end

    // Payload held between accesses
    always_ff @(posedge clk_50) begin
        if (access) begin
            req.is_write <= (req_opcode == WR);
            req.index    <= index_next;
            req.address  <= req_address;
            req.wr_data  <= req_data;
        end
    end

endmodule

// ==== logic/mmio_if.sv ====
`timescale 1ns/10ps

// ------------------------------------------------------------
// Decoded register access, decode stage to execute stage
// ------------------------------------------------------------
interface cr_req_if;
    import mmio_pkg::*;
    import board_cr_pkg::*;

    logic      valid;
    logic      is_write;
    cr_index_t index;
    // Full address kept for the response
    addr_t     address;
    data_t     wr_data;

    modport decode  (output valid, is_write, index, address, wr_data);
    modport execute (input  valid, is_write, index, address, wr_data);
endinterface

// ------------------------------------------------------------
// Access result, execute stage to response pipeline
// ------------------------------------------------------------
interface cr_rsp_if;
    import mmio_pkg::*;

    logic  valid;
    logic  is_write;
    addr_t address;
    // Zero for writes
    data_t rd_data;

    modport execute (output valid, is_write, address, rd_data);
    modport result  (input  valid, is_write, address, rd_data);
endinterface

// ==== logic/board_cr_pkg.sv ====
`include "mmio_params.svh"

package board_cr_pkg;

    // ------------------------------------------------------------
    // Board control register types
    // ------------------------------------------------------------

    // Decoded register selector
    typedef enum logic [3:0] {
        IDX_SEG7_0   = 4'd0,
        IDX_SEG7_1   = 4'd1,
        IDX_SEG7_2   = 4'd2,
        IDX_SEG7_3   = 4'd3,
        IDX_SEG7_4   = 4'd4,
        IDX_SEG7_5   = 4'd5,
        IDX_LED      = 4'd6,
        IDX_BUTTON_0 = 4'd7,
        IDX_BUTTON_1 = 4'd8,
        IDX_SWITCH   = 4'd9,
        // Anything outside the map
        IDX_NONE     = 4'd15
    } cr_index_t;

    // Low address bits seen by the decode
    typedef logic [`MMIO_OFFSET_W-1:0] offset_t;

    // One seven-segment digit, segments a to g
    typedef logic [6:0] seg7_t;

    // LED bank
    typedef logic [6:0] led_t;

    // Slide switches
    typedef logic [9:0] switch_t;

endpackage

// ==== logic/mmio_pkg.sv ====
`include "mmio_params.svh"

package mmio_pkg;

    // ------------------------------------------------------------
    // Fabric transaction types
    // ------------------------------------------------------------

    // Request and response opcodes share one encoding
    typedef enum logic [1:0] {
        RD     = 2'b00,
        WR     = 2'b01,
        RD_RSP = 2'b10,
        WR_RSP = 2'b11
    } opcode_t;

    // Full request address
    typedef logic [`MMIO_ADDR_W-1:0] addr_t;

    // Write data and read data
    typedef logic [`MMIO_DATA_W-1:0] data_t;

endpackage

// ==== logic/mmio_params.svh ====
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Request bus widths
`define MMIO_ADDR_W    32
`define MMIO_DATA_W    32

// Only the low address bits reach the register decode
`define MMIO_OFFSET_W  20

// Requester starts with this many credits
`define MMIO_CREDITS   4

// ------------------------------------------------------------
// Register offsets within the decoded window
// ------------------------------------------------------------
`define CR_SEG7_0      20'h0_0000
`define CR_SEG7_1      20'h0_0004
`define CR_SEG7_2      20'h0_0008
`define CR_SEG7_3      20'h0_000C
`define CR_SEG7_4      20'h0_0010
`define CR_SEG7_5      20'h0_0014
`define CR_LED         20'h0_0018
`define CR_BUTTON_0    20'h0_0020
`define CR_BUTTON_1    20'h0_0024
`define CR_SWITCH      20'h0_0028

`endif
